/* hw/cpuPkg.sv */
`timescale 1ns/1ns
`default_nettype none

package cpuPkg;

  //////////////////////////////////////////////////
  // Machine widths
  //////////////////////////////////////////////////
  localparam int unsigned DataWidth   = 16;  // Word size
  localparam int unsigned RegCount    = 16;  // Architectural registers
  localparam int unsigned RegIdxWidth = 4;   // Bits to address a register

  typedef logic [DataWidth-1:0]   word_t;    // Data or address word
  typedef logic [RegIdxWidth-1:0] regIdx_t;  // Register index

  //////////////////////////////////////////////////
  // Opcodes, instr[15:12]
  //////////////////////////////////////////////////
  typedef enum logic [3:0] {
    opAdd    = 4'h0,  // Saturating signed add
    opSub    = 4'h1,  // Saturating signed subtract
    opXor    = 4'h2,
    opSll    = 4'h4,  // Shift left logical by imm
    opSra    = 4'h5,  // Shift right arithmetic by imm
    opRor    = 4'h6,  // Rotate right by imm
    opPaddsb = 4'h7,  // Four saturating 4-bit lane adds
    opLlb    = 4'hA,  // Load low byte of rd
    opLhb    = 4'hB,  // Load high byte of rd
    opHlt    = 4'hF
  } opcode_t;

  //////////////////////////////////////////////////
  // Stage payloads
  //////////////////////////////////////////////////

  // Decode -> execute
  typedef struct packed {
    opcode_t op;
    regIdx_t rd;       // Destination
    regIdx_t rs;       // Index read on port A (rd for byte loads)
    regIdx_t rt;       // Index read on port B
    word_t   opA;      // Operand from port A
    word_t   opB;      // Operand from port B
    word_t   imm;      // Zero-extended immediate
    logic    writeEn;  // Result goes to rd
    logic    halt;
    word_t   pc;       // Pc at acceptance
  } decoded_t;

  // Execute -> retire
  typedef struct packed {
    word_t   pc;
    regIdx_t rd;
    logic    writeEn;
    logic    halt;
    word_t   result;   // ALU output
  } result_t;

  // Retire record on the outside port, also the register-file write
  typedef struct packed {
    word_t   pc;
    regIdx_t rd;
    logic    writeEn;
    word_t   data;
  } retire_t;

endpackage

`default_nettype wire

/* hw/regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile import cpuPkg::*; (
  input  wire          clk,
  input  wire          rstN,
  input  wire regIdx_t rdIdxA,   // Read port A index
  input  wire regIdx_t rdIdxB,   // Read port B index
  input  wire retire_t wr,       // Write record, rd and data used
  input  wire          wrFire,   // Write strobe
  output word_t        rdDataA,
  output word_t        rdDataB
);

  word_t regs [RegCount];  // Register array
  logic  wrHit;            // Write targets a real register

  assign wrHit = wrFire && (wr.rd != '0);  // r0 drops writes

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < RegCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wrHit) begin
      regs[wr.rd] <= wr.data;
    end
  end

  //////////////////////////////////////////////////
  // Read ports with write-through
  //////////////////////////////////////////////////
  // Same-cycle write wins over stored value
  assign rdDataA = (wrHit && (wr.rd == rdIdxA)) ? wr.data : regs[rdIdxA];
  assign rdDataB = (wrHit && (wr.rd == rdIdxB)) ? wr.data : regs[rdIdxB];

endmodule

`default_nettype wire

/* hw/pipeReg.sv */
`timescale 1ns/1ns
`default_nettype none

module pipeReg #(
  parameter type payload_t = logic  // Stage payload
) (
  input  wire           clk,
  input  wire           rstN,
  input  wire           inValid,
  input  wire payload_t inData,
  output logic          inReady,
  output logic          outValid,
  output payload_t      outData,
  input  wire           outReady
);

  logic loadEn;  // Upstream transfer this cycle

  // Room when empty or when the held entry leaves now
  assign inReady = !outValid || outReady;
  assign loadEn  = inValid && inReady;

  //////////////////////////////////////////////////
  // Occupancy
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;  // Refill or drain
    end
  end

  // Payload, no reset needed
  always_ff @(posedge clk) begin
    if (loadEn) begin
      outData <= inData;
    end
  end

endmodule

`default_nettype wire

/* hw/decodeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeStage import cpuPkg::*; (
  input  wire word_t instr,     // Raw instruction word
  input  wire word_t instrPc,   // Pc it was accepted at
  input  wire word_t rdDataA,   // Register file port A data
  input  wire word_t rdDataB,   // Register file port B data
  output regIdx_t    rdIdxA,
  output regIdx_t    rdIdxB,
  output decoded_t   decoded
);

  //////////////////////////////////////////////////
  // Field split
  //////////////////////////////////////////////////
  opcode_t op;
  regIdx_t rdField;
  regIdx_t rsField;
  regIdx_t rtField;
  logic    isByteLoad;  // LLB or LHB

  assign op      = opcode_t'(instr[15:12]);
  assign rdField = instr[11:8];
  assign rsField = instr[7:4];
  assign rtField = instr[3:0];  // Also the 4-bit immediate

  assign isByteLoad = (op == opLlb) || (op == opLhb);

  //////////////////////////////////////////////////
  // Register file reads
  //////////////////////////////////////////////////
  // Byte loads keep the other half of rd, so port A reads rd
  assign rdIdxA = isByteLoad ? rdField : rsField;
  assign rdIdxB = rtField;

  //////////////////////////////////////////////////
  // Decoded payload
  //////////////////////////////////////////////////
  always_comb begin
    decoded.op  = op;
    decoded.rd  = rdField;
    decoded.rs  = rdIdxA;   // Index actually read, used for forwarding
    decoded.rt  = rtField;
    decoded.opA = rdDataA;
    decoded.opB = rdDataB;

    // 8-bit field for byte loads, low nibble otherwise
    if (isByteLoad) begin
      decoded.imm = word_t'(instr[7:0]);
    end else begin
      decoded.imm = word_t'(instr[3:0]);
    end

    // Undefined opcodes still retire, with no write
    decoded.writeEn = op inside {opAdd, opSub, opXor, opSll, opSra,
                                 opRor, opPaddsb, opLlb, opLhb};
    decoded.halt    = (op == opHlt);
    decoded.pc      = instrPc;
  end

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu import cpuPkg::*; (
  input  wire opcode_t op,
  input  wire word_t   a,     // Operand A
  input  wire word_t   b,     // Operand B
  input  wire word_t   imm,   // Zero-extended immediate
  output word_t        y
);

  //////////////////////////////////////////////////
  // Saturating helpers
  //////////////////////////////////////////////////

  // 16-bit signed add or subtract, clamped on overflow
  function automatic word_t satAddSub(input word_t x, input word_t z, input logic sub);
    word_t zEff;
    word_t sum;
    logic  ovf;
    zEff = sub ? ~z : z;
    sum  = x + zEff + word_t'(sub);  // Two's complement subtract
    ovf  = (x[15] == zEff[15]) && (sum[15] != x[15]);
    if (ovf) begin
      return x[15] ? 16'h8000 : 16'h7FFF;
    end
    return sum;
  endfunction

  // One 4-bit lane, range -8 to 7
  function automatic logic [3:0] satLane(input logic [3:0] x, input logic [3:0] z);
    logic [3:0] sum;
    sum = x + z;
    if ((x[3] == z[3]) && (sum[3] != x[3])) begin
      return x[3] ? 4'h8 : 4'h7;
    end
    return sum;
  endfunction

  //////////////////////////////////////////////////
  // Operation select
  //////////////////////////////////////////////////
  logic [3:0]  shAmt;   // Shift and rotate amount
  logic [31:0] rotTmp;  // Doubled word for rotate

  assign shAmt  = imm[3:0];
  assign rotTmp = {a, a} >> shAmt;

  always_comb begin
    case (op)
      opAdd:    y = satAddSub(a, b, 1'b0);
      opSub:    y = satAddSub(a, b, 1'b1);
      opXor:    y = a ^ b;
      opSll:    y = a << shAmt;
      opSra:    y = word_t'($signed(a) >>> shAmt);
      opRor:    y = rotTmp[15:0];
      opPaddsb: y = {satLane(a[15:12], b[15:12]), satLane(a[11:8], b[11:8]),
                     satLane(a[7:4], b[7:4]), satLane(a[3:0], b[3:0])};
      opLlb:    y = {a[15:8], imm[7:0]};  // New low byte
      opLhb:    y = {imm[7:0], a[7:0]};   // New high byte
      default:  y = '0;                   // HLT and undefined
    endcase
  end

endmodule

`default_nettype wire

/* hw/executeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module executeStage import cpuPkg::*; (
  input  wire decoded_t decoded,   // From the decode pipeReg
  input  wire           fwdValid,  // Result pipeReg holds an entry
  input  wire result_t  fwd,       // Result pipeReg payload
  output result_t       result
);

  //////////////////////////////////////////////////
  // Forwarding select
  //////////////////////////////////////////////////
  logic  fwdLive;  // Producer ahead will write a real register
  logic  fwdA;
  logic  fwdB;
  word_t opA;
  word_t opB;
  word_t aluY;

  assign fwdLive = fwdValid && fwd.writeEn && (fwd.rd != '0);

  assign fwdA = fwdLive && (fwd.rd == decoded.rs);
  assign fwdB = fwdLive && (fwd.rd == decoded.rt);

  // Latched operands may be stale by one instruction
  assign opA = fwdA ? fwd.result : decoded.opA;
  assign opB = fwdB ? fwd.result : decoded.opB;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////
  alu iAlu (
    .op  (decoded.op),
    .a   (opA),
    .b   (opB),
    .imm (decoded.imm),
    .y   (aluY)
  );

  // Result payload
  always_comb begin
    result.pc      = decoded.pc;
    result.rd      = decoded.rd;
    result.writeEn = decoded.writeEn;
    result.halt    = decoded.halt;
    result.result  = aluY;
  end

endmodule

`default_nettype wire

/* hw/retireStage.sv */
`timescale 1ns/1ns
`default_nettype none

module retireStage import cpuPkg::*; (
  input  wire          clk,
  input  wire          rstN,
  input  wire          inValid,      // Result pipeReg holds an entry
  input  wire result_t result,       // Result pipeReg payload
  output logic         inReady,
  output logic         retireValid,
  output retire_t      retire,       // Retire record, also the write port
  input  wire          retireReady,
  output logic         wrFire,       // Register file write strobe
  output logic         hlt
);

  logic recFire;  // Record accepted downstream

  //////////////////////////////////////////////////
  // Retire handshake
  //////////////////////////////////////////////////
  // Halt never waits on the outside port
  assign inReady     = result.halt || retireReady;
  assign retireValid = inValid && !result.halt;
  assign recFire     = retireValid && retireReady;
  assign wrFire      = recFire && result.writeEn;

  always_comb begin
    retire.pc      = result.pc;
    retire.rd      = result.rd;
    retire.writeEn = result.writeEn;
    retire.data    = result.result;
  end

  //////////////////////////////////////////////////
  // Halt capture
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      hlt <= 1'b0;
    end else if (inValid && result.halt) begin
      hlt <= 1'b1;  // Sticky until reset
    end
  end

endmodule

`default_nettype wire

/* hw/cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu import cpuPkg::*; (
  input  wire        clk,
  input  wire        rstN,
  input  wire        instrValid,
  input  wire word_t instr,
  output logic       instrReady,
  output logic       retireValid,
  output retire_t    retire,
  input  wire        retireReady,
  output word_t      pc,          // Pc of the next instruction to accept
  output logic       hlt
);

  logic     halted;      // HLT accepted, no more input
  logic     instrFire;   // Input transfer this cycle
  logic     decInReady;  // Decode pipeReg has room
  regIdx_t  rdIdxA;
  regIdx_t  rdIdxB;
  word_t    rdDataA;
  word_t    rdDataB;
  decoded_t decodedIn;   // Decode output
  decoded_t decodedOut;  // Decode pipeReg output
  logic     decValid;
  result_t  resultIn;    // Execute output
  result_t  resultOut;   // Result pipeReg output
  logic     resInReady;
  logic     resValid;
  logic     retInReady;
  logic     wrFire;

  //////////////////////////////////////////////////
  // Input handshake and pc
  //////////////////////////////////////////////////
  assign instrReady = decInReady && !halted;
  assign instrFire  = instrValid && instrReady;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc     <= '0;
      halted <= 1'b0;
    end else if (instrFire) begin
      pc <= pc + word_t'(2);
      if (opcode_t'(instr[15:12]) == opHlt) begin
        halted <= 1'b1;  // Raw word test, blocks input until reset
      end
    end
  end

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  regFile iRegFile (
    .clk, .rstN, .rdIdxA, .rdIdxB, .wr(retire), .wrFire, .rdDataA, .rdDataB
  );

  decodeStage iDecode (
    .instr, .instrPc(pc), .rdDataA, .rdDataB, .rdIdxA, .rdIdxB, .decoded(decodedIn)
  );

  pipeReg #(.payload_t(decoded_t)) iDecPipe (
    .clk, .rstN,
    .inValid(instrValid && !halted), .inData(decodedIn), .inReady(decInReady),
    .outValid(decValid), .outData(decodedOut), .outReady(resInReady)
  );

  //////////////////////////////////////////////////
  // Execute and retire
  //////////////////////////////////////////////////
  executeStage iExecute (
    .decoded(decodedOut), .fwdValid(resValid), .fwd(resultOut), .result(resultIn)
  );

  pipeReg #(.payload_t(result_t)) iResPipe (
    .clk, .rstN,
    .inValid(decValid), .inData(resultIn), .inReady(resInReady),
    .outValid(resValid), .outData(resultOut), .outReady(retInReady)
  );

  retireStage iRetire (
    .clk, .rstN, .inValid(resValid), .result(resultOut), .inReady(retInReady),
    .retireValid, .retire, .retireReady, .wrFire, .hlt
  );

endmodule

`default_nettype wire

/* sim/clockGen.sv */
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
  parameter int unsigned Period      = 4,  // Clock period in ns
  parameter int unsigned ResetCycles = 3   // Cycles with reset held
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

  // Release lands on a falling edge
  initial begin
    rstN = 1'b0;
    #(Period * ResetCycles) rstN = 1'b1;
  end

endmodule

`default_nettype wire

/* sim/cpuTb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuTb import cpuPkg::*; ();

  localparam int unsigned Seed           = 64127;
  localparam int unsigned RandCount      = 150;  // Instructions in the random test
  localparam int unsigned CyclesPerInstr = 20;
  // Per test: independent, forwarding, saturation, random, r0, halt
  localparam int unsigned TotalInstr     = 13 + 10 + 15 + RandCount + 6 + 6;

  logic    clk;
  logic    rstN;
  logic    instrValid;
  word_t   instr;
  logic    instrReady;
  logic    retireValid;
  retire_t retire;
  logic    retireReady;
  word_t   pc;
  logic    hlt;

  word_t   refRegs [RegCount];    // Reference register model
  retire_t expQ [$];              // Records still to retire
  word_t   expPc;                 // Pc of the next instruction sent
  logic    randomReady = 1'b0;    // Toggle retireReady at random
  int      errorCount  = 0;
  int      checkCount  = 0;

  clockGen #(.Period(4), .ResetCycles(3)) iClockGen (.clk, .rstN);

  cpu cpu_inst (
    .clk, .rstN, .instrValid, .instr, .instrReady,
    .retireValid, .retire, .retireReady, .pc, .hlt
  );

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic checkWord(input string name, input word_t exp, input word_t act);
    checkCount++;
    if (exp !== act) begin
      errorCount++;
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    checkCount++;
    if (exp !== act) begin
      errorCount++;
      $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic checkRecord(input retire_t exp, input retire_t act);
    checkCount++;
    if (exp !== act) begin
      errorCount++;
      $display({"FAIL %0t retire expected pc=%h rd=%0d we=%b data=%h",
                " actual pc=%h rd=%0d we=%b data=%h"},
               $time, exp.pc, exp.rd, exp.writeEn, exp.data,
               act.pc, act.rd, act.writeEn, act.data);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic word_t clampWord(input int s);
    if (s > 32767) return 16'h7FFF;
    if (s < -32768) return 16'h8000;
    return word_t'(s);
  endfunction

  function automatic logic [3:0] clampLane(input int s);
    if (s > 7) return 4'h7;    // Lane maximum
    if (s < -8) return 4'h8;   // Lane minimum, -8
    return s[3:0];
  endfunction

  function automatic word_t expectedData(input opcode_t op, input word_t a, input word_t b,
                                         input word_t imm);
    word_t r;
    int    la;
    int    lb;
    r = '0;
    case (op)
      opAdd: r = clampWord(int'($signed(a)) + int'($signed(b)));
      opSub: r = clampWord(int'($signed(a)) - int'($signed(b)));
      opXor: r = a ^ b;
      opSll: r = a << imm[3:0];
      opSra: begin
        r = a;
        repeat (imm[3:0]) r = {r[15], r[15:1]};  // One step at a time, sign copied
      end
      opRor: begin
        r = a;
        repeat (imm[3:0]) r = {r[0], r[15:1]};
      end
      opPaddsb: begin
        for (int i = 0; i < 4; i++) begin
          la = int'($signed(a[4*i +: 4]));
          lb = int'($signed(b[4*i +: 4]));
          r[4*i +: 4] = clampLane(la + lb);
        end
      end
      opLlb: r = {a[15:8], imm[7:0]};
      opLhb: r = {imm[7:0], a[7:0]};
      default: r = '0;
    endcase
    return r;
  endfunction

  // Step the model by one instruction, queue its record
  task automatic predictRetire(input word_t w);
    opcode_t op;
    logic    byteLoad;
    retire_t rec;
    word_t   a;
    op       = opcode_t'(w[15:12]);
    byteLoad = (op == opLlb) || (op == opLhb);
    a        = byteLoad ? refRegs[w[11:8]] : refRegs[w[7:4]];  // Byte loads keep rd
    if (op != opHlt) begin   // Halt gives no record
      rec.pc      = expPc;
      rec.rd      = w[11:8];
      rec.writeEn = op inside {opAdd, opSub, opXor, opSll, opSra, opRor, opPaddsb,
                               opLlb, opLhb};
      rec.data    = expectedData(op, a, refRegs[w[3:0]],
                                 byteLoad ? word_t'(w[7:0]) : word_t'(w[3:0]));
      expQ.push_back(rec);
      if (rec.writeEn && rec.rd != '0) begin
        refRegs[rec.rd] = rec.data;
      end
    end
    expPc = expPc + 16'd2;
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  function automatic word_t makeRegInstr(input opcode_t op, input int rd, input int rs,
                                         input int rt);
    return {op, regIdx_t'(rd), regIdx_t'(rs), regIdx_t'(rt)};
  endfunction

  function automatic word_t makeByteInstr(input opcode_t op, input int rd, input int imm8);
    return {op, regIdx_t'(rd), imm8[7:0]};
  endfunction

  // Falling edge, new retireReady
  task automatic nextCycle();
    @(negedge clk);
    retireReady = randomReady ? 1'($urandom_range(0, 1)) : 1'b1;
  endtask

  // Hold the word until a rising edge takes it
  task automatic sendInstr(input word_t w);
    logic taken;
    instrValid = 1'b1;
    instr      = w;
    do begin
      @(posedge clk);
      taken = instrReady;
      nextCycle();
    end while (!taken);
    instrValid = 1'b0;
    predictRetire(w);
  endtask

  task automatic loadConst(input int rd, input word_t value);
    sendInstr(makeByteInstr(opLlb, rd, value[7:0]));
    sendInstr(makeByteInstr(opLhb, rd, value[15:8]));
  endtask

  task automatic drainRecords();
    while (expQ.size() != 0) nextCycle();
    checkWord("pc", expPc, pc);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic testIndependent();
    loadConst(1, 16'h1234);
    loadConst(2, 16'hF0F0);
    loadConst(3, 16'h8001);
    sendInstr(makeRegInstr(opXor, 4, 1, 2));
    sendInstr(makeRegInstr(opSll, 5, 1, 4));
    sendInstr(makeRegInstr(opSra, 6, 3, 3));   // Negative value keeps its sign
    sendInstr(makeRegInstr(opRor, 7, 1, 4));
    sendInstr(makeRegInstr(opRor, 8, 2, 0));   // Zero rotate
    sendInstr(makeRegInstr(opSll, 9, 3, 15));
    sendInstr({4'h3, 12'h123});                // Undefined opcode, no write
    drainRecords();
  endtask

  task automatic testForwarding();
    loadConst(1, 16'h0003);
    sendInstr(makeRegInstr(opAdd, 2, 1, 1));
    sendInstr(makeRegInstr(opAdd, 2, 2, 1));   // Both sources just written
    sendInstr(makeRegInstr(opSub, 3, 2, 1));
    sendInstr(makeRegInstr(opXor, 3, 3, 2));
    sendInstr(makeRegInstr(opAdd, 4, 3, 3));
    sendInstr(makeByteInstr(opLlb, 5, 8'h77));
    sendInstr(makeByteInstr(opLhb, 5, 8'h66)); // Keeps the low byte just loaded
    sendInstr(makeRegInstr(opXor, 6, 5, 4));
    drainRecords();
  endtask

  task automatic testSaturation();
    loadConst(1, 16'h7FF0);
    loadConst(2, 16'h0100);
    loadConst(3, 16'h8010);
    loadConst(4, 16'h7839);
    sendInstr(makeRegInstr(opAdd, 6, 1, 2));     // Clamps high
    sendInstr(makeRegInstr(opSub, 7, 3, 2));     // Clamps low
    sendInstr(makeRegInstr(opSub, 8, 1, 3));
    sendInstr(makeRegInstr(opAdd, 9, 3, 3));
    sendInstr(makeRegInstr(opAdd, 10, 1, 3));    // In range
    sendInstr(makeByteInstr(opLlb, 5, 8'h51));
    sendInstr(makeRegInstr(opPaddsb, 11, 4, 4)); // Lanes hit 7 and -8
    drainRecords();
  endtask

  task automatic testBackPressure();
    int opSel;
    randomReady = 1'b1;
    for (int i = 0; i < RandCount; i++) begin
      if ($urandom_range(0, 2) == 0) nextCycle();  // Idle gap with instrValid low
      opSel = $urandom_range(0, 9);
      case (opSel)
        7: sendInstr(makeByteInstr(opLlb, $urandom_range(0, 7), $urandom_range(0, 255)));
        8: sendInstr(makeByteInstr(opLhb, $urandom_range(0, 7), $urandom_range(0, 255)));
        9: sendInstr({4'h3, 12'($urandom_range(0, 4095))});
        default: sendInstr(makeRegInstr(opcode_t'(opSel < 3 ? opSel : opSel + 1),
                                        $urandom_range(0, 7), $urandom_range(0, 7),
                                        $urandom_range(0, 15)));
      endcase
    end
    drainRecords();
    randomReady = 1'b0;
  endtask

  task automatic testZeroRegister();
    loadConst(3, 16'h2A5C);
    sendInstr(makeByteInstr(opLlb, 0, 8'h55));   // Retires with writeEn set
    sendInstr(makeRegInstr(opAdd, 1, 0, 0));     // r0 still reads zero
    sendInstr(makeRegInstr(opXor, 2, 0, 3));
    sendInstr(makeRegInstr(opSub, 4, 3, 0));
    drainRecords();
  endtask

  task automatic testHalt();
    word_t haltPc;
    haltPc = expPc;
    sendInstr(16'hF000);
    while (!hlt) nextCycle();
    // Further input must be refused
    instrValid = 1'b1;
    instr      = makeRegInstr(opAdd, 1, 1, 1);
    repeat (5) begin
      nextCycle();
      checkBit("instrReady", 1'b0, instrReady);
    end
    instrValid = 1'b0;
    checkBit("hlt", 1'b1, hlt);
    checkBit("retireValid", 1'b0, retireValid);
    checkWord("pc", haltPc + 16'd2, pc);
  endtask

  //////////////////////////////////////////////////
  // Retire monitor
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    if (rstN && retireValid && retireReady) begin
      if (expQ.size() == 0) begin
        errorCount++;
        $display("Retire record with pc %h appeared with no instruction pending at %0t",
                 retire.pc, $time);
      end else begin
        checkRecord(expQ.pop_front(), retire);
      end
    end
  end

  // Watchdog sized by the instruction count
  initial begin
    repeat (TotalInstr * CyclesPerInstr) @(posedge clk);
    errorCount++;
    $display("Timeout after %0d cycles, the tests did not finish",
             TotalInstr * CyclesPerInstr);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    $display("tests failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    instrValid  = 1'b0;
    instr       = '0;
    retireReady = 1'b1;
    expPc       = '0;
    for (int i = 0; i < RegCount; i++) refRegs[i] = '0;
    void'($urandom(Seed));
    wait (rstN === 1'b1);
    nextCycle();
    checkBit("retireValid", 1'b0, retireValid);   // Reset state
    checkBit("hlt", 1'b0, hlt);
    checkBit("instrReady", 1'b1, instrReady);
    checkWord("pc", 16'h0000, pc);
    testIndependent();
    testForwarding();
    testSaturation();
    testBackPressure();
    testZeroRegister();
    testHalt();   // Last, halt holds until reset
    if (expQ.size() != 0) begin
      errorCount++;
      $display("%0d expected retire records never arrived", expQ.size());
    end
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
hw/cpuPkg.sv
hw/regFile.sv
hw/pipeReg.sv
hw/decodeStage.sv
hw/alu.sv
hw/executeStage.sv
hw/retireStage.sv
hw/cpu.sv
sim/clockGen.sv
sim/cpuTb.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - hw/cpuPkg.sv
  - hw/regFile.sv
  - hw/pipeReg.sv
  - hw/decodeStage.sv
  - hw/alu.sv
  - hw/executeStage.sv
  - hw/retireStage.sv
  - hw/cpu.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/cpuTb.sv
